// ==== Bender.yml ====
package:
  name: rv32_idu_core

sources:
  - src/core_pkg.sv
  - src/key_mux.sv
  - src/decode_if.sv
  - src/idu.sv
  - src/reg_file.sv
  - src/exu.sv
  - src/ifu.sv
  - src/core_top.sv
  - target: test
    files:
      - tests/tb_core.sv

// ==== src/core_pkg.sv ====
package core_pkg;

    // ==================================================
    // widths and word types
    // ==================================================
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;

    // ==================================================
    // decoder codes
    // ==================================================
    typedef enum logic [2:0] {
        inst_inv,
        inst_auipc,
        inst_jal,
        inst_beq,
        inst_sw,
        inst_addi,
        inst_add,
        inst_ebreak
    } inst_num_e;

    typedef enum logic [2:0] {
        type_n,
        type_r,
        type_i,
        type_s,
        type_b,
        type_u,
        type_j
    } inst_type_e;

    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_beq    = 7'b1100011;
    localparam opcode_t op_sw     = 7'b0100011;
    localparam opcode_t op_addi   = 7'b0010011;
    localparam opcode_t op_add    = 7'b0110011;
    localparam opcode_t op_ebreak = 7'b1110011;

    localparam int nr_inst = 7; // opcodes in the subset.
    localparam int nr_type = 6; // formats that carry an immediate entry.

endpackage

// ==== src/core_top.sv ====
`timescale 1ns/1ps

module core_top #(
    parameter core_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            rst,
    input  core_pkg::inst_t inst,
    output core_pkg::word_t pc,
    output logic            mem_wen,
    output core_pkg::word_t mem_addr,
    output core_pkg::word_t mem_wdata,
    output logic            halt,
    output logic            illegal
);
    import core_pkg::*;

    word_t     rdata1;
    word_t     rdata2;
    logic      wen;
    reg_addr_t waddr;
    word_t     wdata;
    word_t     next_pc;
    logic      halt_req;
    logic      illegal_req;
    logic      stall;

    decode_if dec_bus ();

    idu u_idu (
        .clk  (clk),
        .rst  (rst),
        .inst (inst),
        .dec  (dec_bus)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .rst    (rst),
        .regs   (dec_bus),
        .wen    (wen),
        .waddr  (waddr),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    exu u_exu (
        .exe         (dec_bus),
        .stall       (stall),
        .pc          (pc),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .wen         (wen),
        .waddr       (waddr),
        .wdata       (wdata),
        .next_pc     (next_pc),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .halt_req    (halt_req),
        .illegal_req (illegal_req)
    );

    ifu #(.RESET_PC(RESET_PC)) u_ifu (
        .clk         (clk),
        .rst         (rst),
        .next_pc     (next_pc),
        .halt_req    (halt_req),
        .illegal_req (illegal_req),
        .pc          (pc),
        .halt        (halt),
        .illegal     (illegal),
        .stall       (stall)
    );

endmodule

// ==== src/decode_if.sv ====
`timescale 1ns/1ps

interface decode_if;
    import core_pkg::*;

    inst_num_e  inst_num;
    inst_type_e inst_type;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      imm;

    modport dec (
        output inst_num,
        output inst_type,
        output rd,
        output rs1,
        output rs2,
        output imm
    );

    modport regs (input rs1, input rs2);

    modport exe (input inst_num, input rd, input imm);

endinterface

// ==== src/exu.sv ====
`timescale 1ns/1ps

module exu (
    decode_if.exe               exe,
    input  logic                stall,
    input  core_pkg::word_t     pc,
    input  core_pkg::word_t     rdata1,
    input  core_pkg::word_t     rdata2,
    output logic                wen,
    output core_pkg::reg_addr_t waddr,
    output core_pkg::word_t     wdata,
    output core_pkg::word_t     next_pc,
    output logic                mem_wen,
    output core_pkg::word_t     mem_addr,
    output core_pkg::word_t     mem_wdata,
    output logic                halt_req,
    output logic                illegal_req
);
    import core_pkg::*;

    word_t pc_plus4;
    word_t pc_imm;
    logic  wen_int;
    logic  mem_wen_int;

    assign pc_plus4  = pc + 32'd4;
    assign pc_imm    = pc + exe.imm; // shared by auipc, jal and beq.
    assign waddr     = exe.rd;
    assign mem_addr  = rdata1 + exe.imm;
    assign mem_wdata = rdata2;

    // ==================================================
    // per instruction results
    // ==================================================
    always_comb begin
        wen_int     = 1'b0;
        mem_wen_int = 1'b0;
        wdata       = '0;
        next_pc     = pc_plus4;
        halt_req    = 1'b0;
        illegal_req = 1'b0;
        case (exe.inst_num)
            inst_add: begin
                wen_int = 1'b1;
                wdata   = rdata1 + rdata2;
            end
            inst_addi: begin
                wen_int = 1'b1;
                wdata   = rdata1 + exe.imm;
            end
            inst_auipc: begin
                wen_int = 1'b1;
                wdata   = pc_imm;
            end
            inst_jal: begin
                wen_int = 1'b1;
                wdata   = pc_plus4; // link address.
                next_pc = pc_imm;
            end
            inst_beq: begin
                if (rdata1 == rdata2) begin
                    next_pc = pc_imm;
                end
            end
            inst_sw: mem_wen_int = 1'b1;
            inst_ebreak: halt_req = 1'b1;
            default: illegal_req = 1'b1;
        endcase
    end

    // a stopped core must not touch state.
    assign wen     = wen_int & ~stall;
    assign mem_wen = mem_wen_int & ~stall;

endmodule

// ==== src/idu.sv ====
`timescale 1ns/1ps

module idu (
    input  logic            clk,
    input  logic            rst,
    input  core_pkg::inst_t inst,
    decode_if.dec           dec
);
    import core_pkg::*;

    localparam int num_len  = $bits(inst_num_e);
    localparam int type_len = $bits(inst_type_e);
    localparam int op_len   = $bits(opcode_t);

    opcode_t             opcode;
    logic [num_len-1:0]  num_raw;
    logic [type_len-1:0] type_raw;
    word_t               imm_i;
    word_t               imm_s;
    word_t               imm_b;
    word_t               imm_u;
    word_t               imm_j;

    assign opcode = inst[6:0];

    // ==================================================
    // opcode lookups
    // ==================================================
    key_mux #(.NR_KEY(nr_inst), .KEY_LEN(op_len), .DATA_LEN(num_len)) u_num_mux (
        .out         (num_raw),
        .key         (opcode),
        .default_out (inst_inv),
        .lut         ({op_auipc, inst_auipc, op_jal, inst_jal, op_beq, inst_beq,
                       op_sw, inst_sw, op_addi, inst_addi, op_add, inst_add,
                       op_ebreak, inst_ebreak})
    );

    key_mux #(.NR_KEY(nr_inst), .KEY_LEN(op_len), .DATA_LEN(type_len)) u_type_mux (
        .out         (type_raw),
        .key         (opcode),
        .default_out (type_n),
        .lut         ({op_auipc, type_u, op_jal, type_j, op_beq, type_b,
                       op_sw, type_s, op_addi, type_i, op_add, type_r,
                       op_ebreak, type_i}) // ebreak shares the I layout.
    );

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    key_mux #(.NR_KEY(nr_type), .KEY_LEN(type_len), .DATA_LEN(xlen)) u_imm_mux (
        .out         (dec.imm),
        .key         (type_raw),
        .default_out (word_t'(0)),
        .lut         ({type_r, word_t'(0), type_i, imm_i, type_s, imm_s,
                       type_b, imm_b, type_u, imm_u, type_j, imm_j})
    );

    assign dec.inst_num  = inst_num_e'(num_raw);
    assign dec.inst_type = inst_type_e'(type_raw);
    assign dec.rd        = inst[11:7];
    assign dec.rs1       = inst[19:15];
    assign dec.rs2       = inst[24:20];

endmodule

// ==== src/ifu.sv ====
`timescale 1ns/1ps

module ifu #(
    parameter core_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            rst,
    input  core_pkg::word_t next_pc,
    input  logic            halt_req,
    input  logic            illegal_req,
    output core_pkg::word_t pc,
    output logic            halt,
    output logic            illegal,
    output logic            stall
);
    import core_pkg::*;

    word_t pc_q;
    logic  halt_q;
    logic  illegal_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= RESET_PC;
            halt_q    <= 1'b0;
            illegal_q <= 1'b0;
        end else if (!stall) begin
            halt_q    <= halt_req;
            illegal_q <= illegal_req;
            if (!halt_req && !illegal_req) begin
                pc_q <= next_pc; // a stopping instruction keeps its own address.
            end
        end
    end

    assign stall   = halt_q | illegal_q;
    assign pc      = pc_q;
    assign halt    = halt_q | (halt_req & ~stall);
    assign illegal = illegal_q | (illegal_req & ~stall);

endmodule

// ==== src/key_mux.sv ====
`timescale 1ns/1ps

module key_mux #(
    parameter int NR_KEY   = 2,
    parameter int KEY_LEN  = 1,
    parameter int DATA_LEN = 1
) (
    output logic [DATA_LEN-1:0]                  out,
    input  logic [KEY_LEN-1:0]                   key,
    input  logic [DATA_LEN-1:0]                  default_out,
    input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut
);

    localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

    // each pair is packed as {key, data}, first pair in the top bits.
    always_comb begin
        out = default_out;
        for (int i = 0; i < NR_KEY; i++) begin
            if (lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == key) begin
                out = lut[i*PAIR_LEN +: DATA_LEN];
            end
        end
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                rst,
    decode_if.regs              regs,
    input  logic                wen,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2
);
    import core_pkg::*;

    word_t rf_q [1:31]; // x0 has no storage.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            rf_q[waddr] <= wdata;
        end
    end

    // reads see the value from before this cycle's write.
    assign rdata1 = (regs.rs1 == '0) ? '0 : rf_q[regs.rs1];
    assign rdata2 = (regs.rs2 == '0) ? '0 : rf_q[regs.rs2];

endmodule

// ==== tests/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

    localparam logic [31:0] reset_pc   = 32'h8000_0000;
    localparam logic [31:0] ebreak_pc  = 32'h8000_004c;
    localparam int          prog_depth = 32;
    localparam int          nr_stores  = 8;
    localparam int          wait_limit = 200;

    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jal   = 7'b1101111;
    localparam logic [6:0] opc_beq   = 7'b1100011;
    localparam logic [6:0] opc_sw    = 7'b0100011;
    localparam logic [6:0] opc_addi  = 7'b0010011;
    localparam logic [6:0] opc_add   = 7'b0110011;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        mem_wen;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        halt;
    logic        illegal;

    logic [31:0] prog [prog_depth];
    logic [31:0] exp_addr [nr_stores];
    logic [31:0] exp_data [nr_stores];

    integer      seed;
    logic [31:0] rnd;
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [31:0] val_a;
    logic [31:0] val_b;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          store_count;
    bit          aborted;

    core_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .pc        (pc),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .halt      (halt),
        .illegal   (illegal)
    );

    always #10 clk = ~clk;

    // ==================================================
    // instruction memory and store monitor
    // ==================================================
    function automatic logic [31:0] fetch(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - reset_pc;
        if (offset[31:2] < prog_depth) begin
            return prog[offset[31:2]];
        end
        return 32'h0; // outside the program reads as an illegal word.
    endfunction

    always @(posedge clk) begin
        #1;
        inst = fetch(pc);
    end

    always @(negedge clk) begin
        if (mem_wen === 1'b1) begin
            store_count++;
        end
    end

    // ==================================================
    // instruction encoders
    // ==================================================
    function automatic logic [31:0] addi_inst(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, opc_addi};
    endfunction

    function automatic logic [31:0] add_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, opc_add};
    endfunction

    function automatic logic [31:0] sw_inst(input logic [11:0] off, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], opc_sw};
    endfunction

    function automatic logic [31:0] beq_inst(input logic [12:0] off, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], opc_beq};
    endfunction

    function automatic logic [31:0] jal_inst(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    function automatic logic [31:0] auipc_inst(input logic [19:0] upper, input logic [4:0] rd);
        return {upper, rd, opc_auipc};
    endfunction

    task automatic load_program();
        for (int i = 0; i < prog_depth; i++) begin
            prog[i] = 32'h0;
        end
        prog[0]  = addi_inst(imm_a, 5'd0, 5'd1);
        prog[1]  = addi_inst(imm_b, 5'd0, 5'd2);
        prog[2]  = add_inst(5'd3, 5'd1, 5'd2);
        prog[3]  = addi_inst(12'd5, 5'd1, 5'd0);     // write to x0 is dropped.
        prog[4]  = addi_inst(12'h100, 5'd0, 5'd10);  // x10 is the store base.
        prog[5]  = sw_inst(12'd0, 5'd1, 5'd10);
        prog[6]  = sw_inst(12'd4, 5'd2, 5'd10);
        prog[7]  = sw_inst(12'd8, 5'd3, 5'd10);
        prog[8]  = sw_inst(12'd12, 5'd0, 5'd10);
        prog[9]  = auipc_inst(20'h12345, 5'd4);
        prog[10] = sw_inst(12'd16, 5'd4, 5'd10);
        prog[11] = beq_inst(13'd8, 5'd1, 5'd1);      // taken so the next store is skipped.
        prog[12] = sw_inst(12'd20, 5'd0, 5'd10);
        prog[13] = beq_inst(13'd8, 5'd1, 5'd3);      // x1 and x3 differ so this falls through.
        prog[14] = sw_inst(12'd24, 5'd2, 5'd10);
        prog[15] = jal_inst(21'd8, 5'd5);
        prog[16] = sw_inst(12'd28, 5'd1, 5'd10);
        prog[17] = sw_inst(12'd32, 5'd5, 5'd10);
        prog[18] = sw_inst(12'hff0, 5'd3, 5'd10);    // offset of -16.
        prog[19] = 32'h0010_0073;                    // ebreak at 0x8000_004c.
        exp_addr[0] = 32'h100;
        exp_data[0] = val_a;
        exp_addr[1] = 32'h104;
        exp_data[1] = val_b;
        exp_addr[2] = 32'h108;
        exp_data[2] = val_a + val_b;
        exp_addr[3] = 32'h10c;
        exp_data[3] = 32'h0;
        exp_addr[4] = 32'h110;
        exp_data[4] = reset_pc + 32'h24 + 32'h1234_5000;
        exp_addr[5] = 32'h118;
        exp_data[5] = val_b;
        exp_addr[6] = 32'h120;
        exp_data[6] = reset_pc + 32'h40; // link of the jal at 0x3c.
        exp_addr[7] = 32'h0f0;
        exp_data[7] = val_a + val_b;
    endtask

    // ==================================================
    // checks
    // ==================================================
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail", name);
        end
    endtask

    task automatic check_reset_state();
        if (pc !== reset_pc) report_mismatch("pc", reset_pc, pc);
        if (mem_wen !== 1'b0) report_mismatch("mem_wen", 32'd0, {31'd0, mem_wen});
        if (halt !== 1'b0) report_mismatch("halt", 32'd0, {31'd0, halt});
        if (illegal !== 1'b0) report_mismatch("illegal", 32'd0, {31'd0, illegal});
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = errors;
        rst = 1'b1;
        @(posedge clk);
        for (int c = 1; c < 5; c++) begin
            @(negedge clk);
            check_reset_state();
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        report_test("reset", errs_before);
    endtask

    task automatic check_stores();
        int cycles;
        int errs_before;
        for (int k = 0; k < nr_stores; k++) begin
            errs_before = errors;
            cycles = 0;
            @(negedge clk);
            while (mem_wen !== 1'b1 && cycles < wait_limit) begin
                @(negedge clk);
                cycles++;
            end
            if (mem_wen !== 1'b1) begin
                $display("store %0d: no write to %h within %0d cycles", k, exp_addr[k],
                         wait_limit);
                tests_failed++;
                aborted = 1'b1;
                return;
            end
            if (mem_addr !== exp_addr[k]) report_mismatch("mem_addr", exp_addr[k], mem_addr);
            if (mem_wdata !== exp_data[k]) report_mismatch("mem_wdata", exp_data[k], mem_wdata);
            report_test($sformatf("store %0d", k), errs_before);
        end
    endtask

    task automatic check_halt();
        int cycles;
        int errs_before;
        errs_before = errors;
        cycles = 0;
        while (halt !== 1'b1 && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (halt !== 1'b1) begin
            $display("halt: halt did not rise within %0d cycles", wait_limit);
            tests_failed++;
            aborted = 1'b1;
            return;
        end
        prog[19] = sw_inst(12'd0, 5'd0, 5'd0); // a stopped core must not store.
        for (int c = 0; c < 10; c++) begin
            if (halt !== 1'b1) report_mismatch("halt", 32'd1, {31'd0, halt});
            if (illegal !== 1'b0) report_mismatch("illegal", 32'd0, {31'd0, illegal});
            if (pc !== ebreak_pc) report_mismatch("pc", ebreak_pc, pc);
            if (mem_wen !== 1'b0) report_mismatch("mem_wen", 32'd0, {31'd0, mem_wen});
            @(negedge clk);
        end
        if (store_count != nr_stores) begin
            $display("halt: saw %0d stores where %0d were expected", store_count, nr_stores);
            errors++;
        end
        report_test("halt", errs_before);
    endtask

    task automatic check_illegal();
        int cycles;
        int errs_before;
        errs_before = errors;
        prog[0] = 32'h0; // all-zero word is outside the subset.
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (illegal !== 1'b1 && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (illegal !== 1'b1) begin
            $display("illegal: illegal did not rise within %0d cycles", wait_limit);
            tests_failed++;
            aborted = 1'b1;
            return;
        end
        prog[0] = sw_inst(12'd0, 5'd0, 5'd0); // a stopped core must not store.
        for (int c = 0; c < 10; c++) begin
            if (illegal !== 1'b1) report_mismatch("illegal", 32'd1, {31'd0, illegal});
            if (halt !== 1'b0) report_mismatch("halt", 32'd0, {31'd0, halt});
            if (pc !== reset_pc) report_mismatch("pc", reset_pc, pc);
            if (mem_wen !== 1'b0) report_mismatch("mem_wen", 32'd0, {31'd0, mem_wen});
            @(negedge clk);
        end
        report_test("illegal", errs_before);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        inst = 32'h0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        store_count = 0;
        aborted = 1'b0;
        seed = 32'h2c7c_5a46;
        rnd = $random(seed);
        imm_a = {1'b0, rnd[10:0]};   // positive immediate.
        rnd = $random(seed);
        imm_b = {1'b1, rnd[10:0]};   // negative immediate.
        val_a = {{20{imm_a[11]}}, imm_a};
        val_b = {{20{imm_b[11]}}, imm_b};
        load_program();
        check_reset();
        if (!aborted) check_stores();
        if (!aborted) check_halt();
        if (!aborted) check_illegal();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/core_pkg.sv
src/key_mux.sv
src/decode_if.sv
src/idu.sv
src/reg_file.sv
src/exu.sv
src/ifu.sv
src/core_top.sv
tests/tb_core.sv
